// File: src/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int INDEX_W  = 6;                      // 64 sets per way
    localparam int OFFSET_W = 6;                      // 64-byte lines
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W;
    localparam int LINE_W   = 8 << OFFSET_W;          // one whole line, single memory beat
    localparam int FETCH_W  = 64;                     // two instructions per response
    localparam int NUM_SETS = 1 << INDEX_W;

    // physical byte address
    typedef logic [31:0]         addr_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [FETCH_W-1:0]  fetch_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,       // waiting for a request
        LOOKUP,     // way arrays read, hit known
        MISS,       // memory read outstanding
        REFILL,     // line in return buffer, written to victim way
        INVAL       // index invalidate of one way
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: src/icache_way.sv
`timescale 1ns/1ps
`default_nettype none

module icache_way (
    input  wire                     clk,
    input  wire                     rstn,
    // lookup
    input  wire icache_pkg::index_t i_rd_index,     // presented one cycle before the compare
    input  wire icache_pkg::tag_t   i_lookup_tag,
    // refill and invalidate
    input  wire                     i_wr_en,
    input  wire                     i_clr_en,
    input  wire icache_pkg::index_t i_wr_index,
    input  wire icache_pkg::tag_t   i_wr_tag,
    input  wire icache_pkg::line_t  i_wr_line,
    // results
    output logic                    o_hit,
    output icache_pkg::line_t       o_line
);
    import icache_pkg::*;

    logic [NUM_SETS-1:0] valid_q;           // one valid bit per set
    tag_t                tag_mem  [NUM_SETS];
    line_t               line_mem [NUM_SETS];

    logic                valid_rd;
    tag_t                tag_rd;

    // valid bits live in flops so reset can clear them all at once
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (i_wr_en) begin
            valid_q[i_wr_index] <= 1'b1;
        end else if (i_clr_en) begin
            valid_q[i_wr_index] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_rd <= 1'b0;
        end else begin
            valid_rd <= valid_q[i_rd_index];
        end
    end

    // tag and data arrays, synchronous read
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[i_wr_index]  <= i_wr_tag;
            line_mem[i_wr_index] <= i_wr_line;
        end
        tag_rd <= tag_mem[i_rd_index];
        o_line <= line_mem[i_rd_index];
    end

    // compare against the tag of the buffered request
    assign o_hit = valid_rd && (tag_rd == i_lookup_tag);

    // refill and invalidate come from different controller states
    wr_clr_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(i_wr_en && i_clr_en));

endmodule

`default_nettype wire

// File: src/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  wire                     clk,
    input  wire                     rstn,
    // pipeline requests
    input  wire                     i_req_valid,
    input  wire icache_pkg::addr_t  i_req_addr,
    input  wire                     i_req_uncached,
    input  wire                     i_inv_valid,        // index invalidate with addr bit 0 as way
    input  wire                     i_flush,
    // pipeline responses
    output logic                    o_req_ready,
    output logic                    o_resp_valid,
    output icache_pkg::fetch_t      o_resp_data,
    output icache_pkg::addr_t       o_resp_pc,
    output logic                    o_resp_adef,
    output logic                    o_inv_done,
    // memory read port
    output logic                    o_mem_rvalid,
    output icache_pkg::addr_t       o_mem_raddr,
    output logic                    o_mem_uncached,
    input  wire                     i_mem_rready,
    input  wire icache_pkg::line_t  i_mem_rdata,
    // way interface
    output icache_pkg::index_t      o_rd_index,
    output icache_pkg::tag_t        o_lookup_tag,
    output logic                    o_wr_en0,
    output logic                    o_wr_en1,
    output logic                    o_clr_en0,
    output logic                    o_clr_en1,
    output icache_pkg::index_t      o_wr_index,
    output icache_pkg::tag_t        o_wr_tag,
    output icache_pkg::line_t       o_wr_line,
    input  wire                     i_hit0,
    input  wire                     i_hit1,
    input  wire icache_pkg::line_t  i_line0,
    input  wire icache_pkg::line_t  i_line1
);
    import icache_pkg::*;

    ctrl_state_t         state_q;
    ctrl_state_t         state_d;

    // request buffer
    addr_t               addr_q;
    logic                unc_q;
    logic                live_q;            // dropped by flush while in flight

    line_t               ret_buf;           // memory return buffer
    logic [NUM_SETS-1:0] lru_q;             // way to replace next

    index_t              buf_index;
    tag_t                buf_tag;
    logic                adef;
    logic                hit;
    logic                hit_way;
    logic                victim;
    logic                resp_done;
    logic                accept_req;
    logic                accept_inv;
    logic                resp_fire;
    line_t               src_line;
    logic [2:0]          word_sel;
    fetch_t              line_word;

    assign buf_index = addr_q[OFFSET_W +: INDEX_W];
    assign buf_tag   = addr_q[OFFSET_W+INDEX_W +: TAG_W];
    assign adef      = |addr_q[1:0];        // fetch must be word aligned

    // hit combine
    assign hit       = i_hit0 | i_hit1;
    assign hit_way   = i_hit1;              // tags are unique within a set
    assign victim    = lru_q[buf_index];

    // lookup finishes in one cycle on a cached hit or a misaligned address
    assign resp_done = adef || (hit && !unc_q);

    assign o_req_ready = (state_q == IDLE) || ((state_q == LOOKUP) && resp_done);
    assign accept_inv  = o_req_ready && i_inv_valid;
    assign accept_req  = o_req_ready && i_req_valid && !i_inv_valid;

    always_ff @(posedge clk) begin
        if (accept_req || accept_inv) begin
            addr_q <= i_req_addr;
            unc_q  <= i_req_uncached && !i_inv_valid;
        end
    end

    // a new request is live even if flush arrives with it
    always_ff @(posedge clk) begin
        if (!rstn) begin
            live_q <= 1'b0;
        end else if (accept_req) begin
            live_q <= 1'b1;
        end else if (i_flush) begin
            live_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == MISS) && i_mem_rready) begin
            ret_buf <= i_mem_rdata;
        end
    end

    // lru bit names the least recently used way of the set
    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if ((state_q == LOOKUP) && !adef && !unc_q && hit) begin
            lru_q[buf_index] <= !hit_way;
        end else if ((state_q == REFILL) && !unc_q) begin
            lru_q[buf_index] <= !victim;    // refilled way becomes most recent
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (accept_inv) begin
                    state_d = INVAL;
                end else if (accept_req) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!resp_done) begin
                    state_d = MISS;         // cache miss or uncached fetch
                end else if (accept_inv) begin
                    state_d = INVAL;
                end else if (accept_req) begin
                    state_d = LOOKUP;
                end else begin
                    state_d = IDLE;
                end
            end
            MISS: begin
                if (i_mem_rready) begin
                    state_d = REFILL;
                end
            end
            REFILL:  state_d = IDLE;        // ways written here before any new lookup
            INVAL:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // way control
    assign o_rd_index   = i_req_addr[OFFSET_W +: INDEX_W];
    assign o_lookup_tag = buf_tag;
    assign o_wr_index   = buf_index;
    assign o_wr_tag     = buf_tag;
    assign o_wr_line    = ret_buf;
    assign o_wr_en0     = (state_q == REFILL) && !unc_q && !victim;
    assign o_wr_en1     = (state_q == REFILL) && !unc_q && victim;
    assign o_clr_en0    = (state_q == INVAL) && !addr_q[0];
    assign o_clr_en1    = (state_q == INVAL) && addr_q[0];

    // memory request held for the whole MISS state
    assign o_mem_rvalid   = (state_q == MISS);
    assign o_mem_uncached = unc_q;
    assign o_mem_raddr    = unc_q ? {addr_q[31:3], 3'b000}
                                  : {addr_q[31:OFFSET_W], {OFFSET_W{1'b0}}};

    // response word select
    assign src_line  = (state_q == REFILL) ? ret_buf : (hit_way ? i_line1 : i_line0);
    assign word_sel  = addr_q[OFFSET_W-1:3];
    assign line_word = src_line[word_sel*FETCH_W +: FETCH_W];

    assign o_resp_data  = unc_q ? ret_buf[FETCH_W-1:0] : line_word;   // uncached in low bits
    assign resp_fire    = ((state_q == LOOKUP) && resp_done) || (state_q == REFILL);
    assign o_resp_valid = resp_fire && live_q && !i_flush;
    assign o_resp_pc    = addr_q;
    assign o_resp_adef  = adef;
    assign o_inv_done   = (state_q == INVAL);

    // a line never sits in both ways of one set
    hit_one_way: assert property (@(posedge clk) disable iff (!rstn)
        (state_q == LOOKUP) |-> !(i_hit0 && i_hit1));

    // read request and address stay put until memory takes them
    mem_req_held: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rvalid && !i_mem_rready |=> o_mem_rvalid && $stable(o_mem_raddr));

endmodule

`default_nettype wire

// File: src/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire                     clk,
    input  wire                     rstn,
    // pipeline side
    input  wire                     i_req_valid,
    input  wire icache_pkg::addr_t  i_req_addr,
    input  wire                     i_req_uncached,
    input  wire                     i_inv_valid,
    input  wire                     i_flush,
    output logic                    o_req_ready,
    output logic                    o_resp_valid,
    output icache_pkg::fetch_t      o_resp_data,
    output icache_pkg::addr_t       o_resp_pc,
    output logic                    o_resp_adef,
    output logic                    o_inv_done,
    // memory side
    output logic                    o_mem_rvalid,
    output icache_pkg::addr_t       o_mem_raddr,
    output logic                    o_mem_uncached,
    input  wire                     i_mem_rready,
    input  wire icache_pkg::line_t  i_mem_rdata
);
    import icache_pkg::*;

    index_t rd_index;
    index_t wr_index;
    tag_t   lookup_tag;
    tag_t   wr_tag;
    line_t  wr_line;
    line_t  line0;
    line_t  line1;
    logic   wr_en0;
    logic   wr_en1;
    logic   clr_en0;
    logic   clr_en1;
    logic   hit0;
    logic   hit1;

    icache_way way0 (
        .clk          (clk),
        .rstn         (rstn),
        .i_rd_index   (rd_index),
        .i_lookup_tag (lookup_tag),
        .i_wr_en      (wr_en0),
        .i_clr_en     (clr_en0),
        .i_wr_index   (wr_index),
        .i_wr_tag     (wr_tag),
        .i_wr_line    (wr_line),
        .o_hit        (hit0),
        .o_line       (line0)
    );

    icache_way way1 (
        .clk          (clk),
        .rstn         (rstn),
        .i_rd_index   (rd_index),
        .i_lookup_tag (lookup_tag),
        .i_wr_en      (wr_en1),
        .i_clr_en     (clr_en1),
        .i_wr_index   (wr_index),
        .i_wr_tag     (wr_tag),
        .i_wr_line    (wr_line),
        .o_hit        (hit1),
        .o_line       (line1)
    );

    icache_ctrl ctrl0 (
        .clk            (clk),
        .rstn           (rstn),
        .i_req_valid    (i_req_valid),
        .i_req_addr     (i_req_addr),
        .i_req_uncached (i_req_uncached),
        .i_inv_valid    (i_inv_valid),
        .i_flush        (i_flush),
        .o_req_ready    (o_req_ready),
        .o_resp_valid   (o_resp_valid),
        .o_resp_data    (o_resp_data),
        .o_resp_pc      (o_resp_pc),
        .o_resp_adef    (o_resp_adef),
        .o_inv_done     (o_inv_done),
        .o_mem_rvalid   (o_mem_rvalid),
        .o_mem_raddr    (o_mem_raddr),
        .o_mem_uncached (o_mem_uncached),
        .i_mem_rready   (i_mem_rready),
        .i_mem_rdata    (i_mem_rdata),
        .o_rd_index     (rd_index),
        .o_lookup_tag   (lookup_tag),
        .o_wr_en0       (wr_en0),
        .o_wr_en1       (wr_en1),
        .o_clr_en0      (clr_en0),
        .o_clr_en1      (clr_en1),
        .o_wr_index     (wr_index),
        .o_wr_tag       (wr_tag),
        .o_wr_line      (wr_line),
        .i_hit0         (hit0),
        .i_hit1         (hit1),
        .i_line0        (line0),
        .i_line1        (line1)
    );

endmodule

`default_nettype wire

// File: testbench/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
    parameter logic [31:0] PATTERN = 32'h0
) (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     i_rvalid,
    input  wire icache_pkg::addr_t  i_raddr,
    input  wire                     i_uncached,
    output logic                    o_rready,
    output icache_pkg::line_t       o_rdata
);
    import icache_pkg::*;

    integer seed;
    int     wait_cnt;
    logic   busy;

    // word k of a beat holds the pattern for byte address base + 4k
    function automatic line_t beat_at(input addr_t base);
        line_t beat;
        for (int k = 0; k < LINE_W / 32; k++) begin
            beat[32*k +: 32] = (base + 4 * k) ^ PATTERN;
        end
        return beat;
    endfunction

    initial begin
        seed     = 38;
        busy     = 1'b0;
        wait_cnt = 0;
        o_rready = 1'b0;
        o_rdata  = '0;
        forever begin
            @(posedge clk);
            #1;                                     // drive just after the edge
            if (!rstn) begin
                busy     = 1'b0;
                o_rready = 1'b0;
            end else if (o_rready) begin
                o_rready = 1'b0;                    // beat taken at this edge
                busy     = 1'b0;
            end else if (busy) begin
                if (wait_cnt == 0) begin
                    o_rready = 1'b1;
                    o_rdata  = beat_at(i_raddr);
                    if (i_uncached) begin
                        o_rdata[LINE_W-1:FETCH_W] = '0;   // only 8 bytes come back
                    end
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end else if (i_rvalid) begin
                busy     = 1'b1;
                wait_cnt = $unsigned($random(seed)) % 4;   // answer in 1 to 4 cycles
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache;
    import icache_pkg::*;

    localparam logic [31:0] PATTERN = 32'h5A5A0000;
    localparam int NROWS    = 23;
    localparam int LIMIT    = 40 * NROWS + 8;   // rows plus reset
    localparam int OP_FETCH = 0;
    localparam int OP_UNC   = 1;
    localparam int OP_INV   = 2;
    localparam int OP_FLUSH = 3;
    localparam int RC_DATA  = 0;                // response classes
    localparam int RC_ADEF  = 1;
    localparam int RC_NONE  = 2;
    localparam int RC_INV   = 3;

    logic   clk;
    logic   rstn;
    logic   req_valid;
    addr_t  req_addr;
    logic   req_uncached;
    logic   inv_valid;
    logic   flush;
    logic   req_ready;
    logic   resp_valid;
    fetch_t resp_data;
    addr_t  resp_pc;
    logic   resp_adef;
    logic   inv_done;
    logic   mem_rvalid;
    addr_t  mem_raddr;
    logic   mem_uncached;
    logic   mem_rready;
    line_t  mem_rdata;

    string  row_name [NROWS];
    int     row_op   [NROWS];
    addr_t  row_addr [NROWS];
    int     row_mem  [NROWS];
    int     row_cls  [NROWS];
    int     nrows_loaded;

    // reference tags, valid bits and lru per set
    tag_t   m_tag   [NUM_SETS][2];
    logic   m_valid [NUM_SETS][2];
    logic   m_lru   [NUM_SETS];

    int     errors;
    int     cycles;

    icache_top dut0 (
        .clk            (clk),
        .rstn           (rstn),
        .i_req_valid    (req_valid),
        .i_req_addr     (req_addr),
        .i_req_uncached (req_uncached),
        .i_inv_valid    (inv_valid),
        .i_flush        (flush),
        .o_req_ready    (req_ready),
        .o_resp_valid   (resp_valid),
        .o_resp_data    (resp_data),
        .o_resp_pc      (resp_pc),
        .o_resp_adef    (resp_adef),
        .o_inv_done     (inv_done),
        .o_mem_rvalid   (mem_rvalid),
        .o_mem_raddr    (mem_raddr),
        .o_mem_uncached (mem_uncached),
        .i_mem_rready   (mem_rready),
        .i_mem_rdata    (mem_rdata)
    );

    mem_model #(.PATTERN(PATTERN)) mem0 (
        .clk        (clk),
        .rstn       (rstn),
        .i_rvalid   (mem_rvalid),
        .i_raddr    (mem_raddr),
        .i_uncached (mem_uncached),
        .o_rready   (mem_rready),
        .o_rdata    (mem_rdata)
    );

    always #2 clk = ~clk;

    // two words at the 8-byte aligned address with the higher one on top
    function automatic fetch_t word_pair(input addr_t a);
        addr_t a8;
        a8 = {a[31:3], 3'b000};
        return {(a8 + 32'd4) ^ PATTERN, a8 ^ PATTERN};
    endfunction

    task automatic add_row(input string name, input int op, input addr_t a,
                           input int mem, input int cls);
        row_name[nrows_loaded] = name;
        row_op[nrows_loaded]   = op;
        row_addr[nrows_loaded] = a;
        row_mem[nrows_loaded]  = mem;
        row_cls[nrows_loaded]  = cls;
        nrows_loaded++;
    endtask

    task automatic load_table();
        add_row("miss_first",   OP_FETCH, 32'h0000_0400, 1, RC_DATA);
        add_row("hit_same",     OP_FETCH, 32'h0000_0408, 0, RC_DATA);
        add_row("hit_end",      OP_FETCH, 32'h0000_043C, 0, RC_DATA);
        add_row("hit_mid",      OP_FETCH, 32'h0000_0424, 0, RC_DATA);
        add_row("fill_a",       OP_FETCH, 32'h0000_10C0, 1, RC_DATA);   // set 3
        add_row("fill_b",       OP_FETCH, 32'h0000_20C4, 1, RC_DATA);
        add_row("touch_a",      OP_FETCH, 32'h0000_10C8, 0, RC_DATA);
        add_row("fill_c",       OP_FETCH, 32'h0000_30C0, 1, RC_DATA);   // evicts b
        add_row("hit_a",        OP_FETCH, 32'h0000_10D0, 0, RC_DATA);
        add_row("miss_b",       OP_FETCH, 32'h0000_20C0, 1, RC_DATA);
        add_row("unc_fetch",    OP_UNC,   32'h0000_5204, 1, RC_DATA);
        add_row("unc_again",    OP_UNC,   32'h0000_5208, 1, RC_DATA);
        add_row("after_unc",    OP_FETCH, 32'h0000_5200, 1, RC_DATA);
        add_row("misaligned",   OP_FETCH, 32'h0000_0402, 0, RC_ADEF);
        add_row("misalign_unc", OP_UNC,   32'h0000_0601, 0, RC_ADEF);
        add_row("inv_way0",     OP_INV,   32'h0000_10C0, 0, RC_INV);
        add_row("refetch_a",    OP_FETCH, 32'h0000_10C0, 1, RC_DATA);
        add_row("inv_way1",     OP_INV,   32'h0000_20C1, 0, RC_INV);    // bit 0 picks way 1
        add_row("refetch_b",    OP_FETCH, 32'h0000_20C0, 1, RC_DATA);
        add_row("flush_miss",   OP_FLUSH, 32'h0000_7000, 1, RC_NONE);
        add_row("after_flush",  OP_FETCH, 32'h0000_7010, 0, RC_DATA);
        add_row("flush_hit",    OP_FLUSH, 32'h0000_7018, 0, RC_NONE);
        add_row("hit_post",     OP_FETCH, 32'h0000_7000, 0, RC_DATA);
    endtask

    // steps the reference lru model and returns 1 when a memory read is due
    task automatic predict_mem(input int op, input addr_t a, output int mem);
        index_t set;
        tag_t   tag;
        logic   way;
        set = a[OFFSET_W +: INDEX_W];
        tag = a[31:OFFSET_W+INDEX_W];
        mem = 0;
        if (op == OP_INV) begin
            m_valid[set][a[0]] = 1'b0;
        end else if (a[1:0] == 2'b00) begin      // misaligned never reaches memory
            if (op == OP_UNC) begin
                mem = 1;                         // allocates nothing
            end else if (m_valid[set][0] && m_tag[set][0] == tag) begin
                m_lru[set] = 1'b1;
            end else if (m_valid[set][1] && m_tag[set][1] == tag) begin
                m_lru[set] = 1'b0;
            end else begin
                way               = m_lru[set];
                m_tag[set][way]   = tag;
                m_valid[set][way] = 1'b1;
                m_lru[set]        = !way;
                mem               = 1;
            end
        end
    endtask

    task automatic report_mismatch(input string test, input string what,
                                   input logic [63:0] exp, input logic [63:0] act);
        $display("ERR %s %s expected %0h actual %0h", test, what, exp, act);
        errors++;
    endtask

    task automatic run_row(input int r);
        int     model_mem;
        int     mem_cnt;
        int     resp_cnt;
        int     done_cnt;
        int     exp_resp;
        int     exp_done;
        int     cyc;
        bit     done;
        fetch_t data_seen;
        addr_t  pc_seen;
        logic   adef_seen;
        addr_t  raddr_seen;
        logic   unc_seen;
        addr_t  a;
        addr_t  exp_raddr;
        a         = row_addr[r];
        mem_cnt   = 0;
        resp_cnt  = 0;
        done_cnt  = 0;
        cyc       = 0;
        done      = 1'b0;
        data_seen = '0;
        pc_seen   = '0;
        adef_seen = 1'b0;
        raddr_seen = '0;
        unc_seen  = 1'b0;
        predict_mem(row_op[r], a, model_mem);
        assert (model_mem == row_mem[r]) else begin
            $display("table row %s disagrees with the LRU model", row_name[r]);
            errors++;
        end
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        req_addr     = a;
        req_uncached = (row_op[r] == OP_UNC);
        inv_valid    = (row_op[r] == OP_INV);
        req_valid    = (row_op[r] != OP_INV);
        @(posedge clk);                             // accepted here
        #1;
        req_valid    = 1'b0;
        inv_valid    = 1'b0;
        req_uncached = 1'b0;
        while (!done) begin
            flush = (row_op[r] == OP_FLUSH) && (cyc == 0);   // hits the request in flight
            @(negedge clk);
            if (mem_rvalid && mem_rready) begin
                mem_cnt++;
                raddr_seen = mem_raddr;
                unc_seen   = mem_uncached;
            end
            if (resp_valid) begin
                resp_cnt++;
                data_seen = resp_data;
                pc_seen   = resp_pc;
                adef_seen = resp_adef;
            end
            if (inv_done) begin
                done_cnt++;
            end
            done = req_ready;
            @(posedge clk);
            #1;
            cyc++;
        end
        flush = 1'b0;

        exp_resp  = (row_cls[r] == RC_DATA || row_cls[r] == RC_ADEF) ? 1 : 0;
        exp_done  = (row_cls[r] == RC_INV) ? 1 : 0;
        exp_raddr = (row_op[r] == OP_UNC) ? (a & ~32'h7)
                                          : (a & ~32'h3F);
        assert (mem_cnt == row_mem[r]) else
            report_mismatch(row_name[r], "mem reads", 64'(row_mem[r]), 64'(mem_cnt));
        assert (resp_cnt == exp_resp) else
            report_mismatch(row_name[r], "responses", 64'(exp_resp), 64'(resp_cnt));
        assert (done_cnt == exp_done) else
            report_mismatch(row_name[r], "inv done", 64'(exp_done), 64'(done_cnt));
        if (mem_cnt == 1) begin
            assert (raddr_seen == exp_raddr) else
                report_mismatch(row_name[r], "mem addr", 64'(exp_raddr), 64'(raddr_seen));
            assert (unc_seen == (row_op[r] == OP_UNC)) else
                report_mismatch(row_name[r], "mem uncached", 64'(row_op[r] == OP_UNC),
                                64'(unc_seen));
        end
        if (resp_cnt == 1) begin
            assert (pc_seen == a) else
                report_mismatch(row_name[r], "pc", 64'(a), 64'(pc_seen));
            assert (adef_seen == (row_cls[r] == RC_ADEF)) else
                report_mismatch(row_name[r], "adef", 64'(row_cls[r] == RC_ADEF),
                                64'(adef_seen));
            if (row_cls[r] == RC_DATA) begin
                assert (data_seen == word_pair(a)) else
                    report_mismatch(row_name[r], "data", word_pair(a), data_seen);
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_uncached = 1'b0;
        inv_valid    = 1'b0;
        flush        = 1'b0;
        errors       = 0;
        nrows_loaded = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
            m_tag[s][0]   = '0;
            m_tag[s][1]   = '0;
            m_lru[s]      = 1'b0;
        end
        load_table();
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        assert (req_ready && !resp_valid && !mem_rvalid && !inv_done) else begin
            $display("outputs not idle after reset");
            errors++;
        end
        @(posedge clk);
        #1;
        for (int r = 0; r < nrows_loaded; r++) begin
            run_row(r);
        end
        $display("rows run: %0d, errors: %0d", nrows_loaded, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles with %0d errors", LIMIT, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
src/icache_pkg.sv
src/icache_way.sv
src/icache_ctrl.sv
src/icache_top.sv
testbench/mem_model.sv
testbench/tb_icache.sv

// File: run.sh
#!/bin/sh
# compile and run the icache testbench, pass is decided from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_icache -f verilog.f -o tb_icache \
    && ./obj_dir/tb_icache > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Testbench passed" sim.log || exit 1
